/* verilog/cpuTypesPkg.sv */
package cpuTypesPkg;

	localparam int WORD_WIDTH   = 12;  // Memory and instruction word
	localparam int DATA_WIDTH   = 8;   // Accumulator width
	localparam int ADDR_WIDTH   = 8;   // PC and memory address
	localparam int OPCODE_WIDTH = 4;   // Top bits of a word
	localparam int MEM_DEPTH    = 256;

	typedef logic [WORD_WIDTH-1:0] wordT;
	typedef logic [DATA_WIDTH-1:0] dataT;
	typedef logic [ADDR_WIDTH-1:0] addrT;

	// Opcodes not listed here execute as NOP
	typedef enum logic [OPCODE_WIDTH-1:0] {
		NOP  = 4'h0,
		LDI  = 4'h1,  // acc = operand
		LDA  = 4'h2,  // acc = mem[operand]
		STA  = 4'h3,  // mem[operand] = acc
		ADD  = 4'h4,  // acc += mem[operand]
		ADDI = 4'h5,  // acc += operand
		JMP  = 4'h6,  // pc = operand
		HALT = 4'hF   // PC holds, instruction repeats
	} opcodeT;

endpackage

/* verilog/debugTypesPkg.sv */
package debugTypesPkg;

	// Debug addresses cover the whole memory
	localparam int DEBUG_ADDR_WIDTH = cpuTypesPkg::ADDR_WIDTH;
	localparam int DEBUG_DATA_WIDTH = cpuTypesPkg::WORD_WIDTH;  // Full word readback

	typedef logic [DEBUG_ADDR_WIDTH-1:0] debugAddrT;  // Breakpoint, watch, read address
	typedef logic [DEBUG_DATA_WIDTH-1:0] debugDataT;

endpackage

/* verilog/masterSequencer.sv */
module masterSequencer (
	input  logic CLK,
	input  logic RESET,
	input  logic debugReq,
	input  logic debugModeStop,
	input  logic debugModeInc,
	input  logic atBreakpoint,
	input  logic inWatch,
	input  logic haltRequest,
	output logic stopped,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic debugAck,
	output logic readAddrInc,
	output logic halted,
	output logic pcEnable,
	output logic debugActive
);

	typedef enum logic [3:0] {
		phStopped,
		phFetch,
		phDecode,
		phExecute,
		phCommit,
		phDebugStopped,
		phDebugDecode,
		phDebugExecute,
		phDebugCommit,
		phDebugFetch,
		phDebugAck
	} phaseT;

	phaseT phase;
	phaseT phaseNext;
	logic resetR;           // High for the first cycle after reset
	logic reqArmed;         // One debug cycle per request level
	logic stopCondition;
	logic debugActiveNext;

	assign stopCondition = debugModeStop | atBreakpoint | inWatch;

	assign debugActiveNext = (phaseNext == phDebugStopped) || (phaseNext == phDebugDecode) ||
		(phaseNext == phDebugExecute) || (phaseNext == phDebugCommit) ||
		(phaseNext == phDebugFetch) || (phaseNext == phDebugAck);

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			resetR   <= 1'b1;
			pcEnable <= 1'b0;
		end else begin
			resetR   <= 1'b0;
			pcEnable <= ~debugActiveNext & ~resetR;  // PC frozen while in debug
		end
	end

	// Disarm on entry to a debug cycle, re-arm once the request drops
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			reqArmed <= 1'b1;
		end else if (phaseNext == phDebugDecode) begin
			reqArmed <= 1'b0;
		end else if (phaseNext == phDebugStopped && !debugReq) begin
			reqArmed <= 1'b1;
		end
	end

	always_comb begin
		case (phase)
			phStopped: begin
				if (stopCondition) begin
					phaseNext = phDebugStopped;
				end else if (resetR) begin
					phaseNext = phStopped;  // One extra cycle out of reset
				end else begin
					phaseNext = phFetch;
				end
			end
			phFetch:        phaseNext = stopCondition ? phDebugStopped : phDecode;
			phDecode:       phaseNext = phExecute;
			phExecute:      phaseNext = phCommit;
			phCommit:       phaseNext = phFetch;
			phDebugStopped: begin
				if (debugReq && reqArmed) begin
					phaseNext = phDebugDecode;
				end else if (!stopCondition) begin
					phaseNext = phStopped;
				end else begin
					phaseNext = phDebugStopped;
				end
			end
			phDebugDecode:  phaseNext = phDebugExecute;
			phDebugExecute: phaseNext = phDebugCommit;
			phDebugCommit:  phaseNext = phDebugFetch;
			phDebugFetch:   phaseNext = phDebugAck;
			phDebugAck:     phaseNext = phDebugStopped;
			default:        phaseNext = phStopped;  // Unused encodings
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase       <= phStopped;
			stopped     <= 1'b1;
			fetch       <= 1'b0;
			decode      <= 1'b0;
			execute     <= 1'b0;
			commit      <= 1'b0;
			debugAck    <= 1'b0;
			readAddrInc <= 1'b0;
			halted      <= 1'b0;
			debugActive <= 1'b0;
		end else begin
			phase       <= phaseNext;
			stopped     <= (phaseNext == phStopped) || (phaseNext == phDebugStopped) ||
				(phaseNext == phDebugAck);
			fetch       <= (phaseNext == phFetch) || (phaseNext == phDebugFetch);
			decode      <= (phaseNext == phDecode) || (phaseNext == phDebugDecode);
			execute     <= (phaseNext == phExecute) || (phaseNext == phDebugExecute);
			commit      <= (phaseNext == phCommit) || (phaseNext == phDebugCommit);
			debugAck    <= phaseNext == phDebugAck;
			readAddrInc <= (phaseNext == phDebugAck) && debugModeInc;
			halted      <= ((phaseNext == phDecode) || (phaseNext == phDebugDecode)) && haltRequest;
			debugActive <= debugActiveNext;
		end
	end

endmodule

/* verilog/instructionCore.sv */
module instructionCore (
	input  logic               CLK,
	input  logic               RESET,
	input  logic               fetch,
	input  logic               decode,
	input  logic               execute,
	input  logic               commit,
	input  logic               pcEnable,
	input  logic               debugActive,
	input  cpuTypesPkg::wordT  debugInstruction,
	input  cpuTypesPkg::wordT  memReadData,
	output cpuTypesPkg::addrT  memAddr,
	output cpuTypesPkg::addrT  pc,
	output cpuTypesPkg::dataT  accumulator,
	output logic               haltRequest,
	output logic               storeEnable,
	output cpuTypesPkg::addrT  storeAddr,
	output cpuTypesPkg::dataT  storeData
);

	cpuTypesPkg::wordT   instr;        // Instruction register
	cpuTypesPkg::wordT   operandWord;  // Memory word at the operand address
	cpuTypesPkg::opcodeT opcode;
	cpuTypesPkg::opcodeT fetchOpcode;  // Opcode of the word at pc
	cpuTypesPkg::addrT   operandAddr;
	cpuTypesPkg::dataT   operandData;
	cpuTypesPkg::dataT   memValue;

	assign opcode = cpuTypesPkg::opcodeT'(
		instr[cpuTypesPkg::WORD_WIDTH-1 -: cpuTypesPkg::OPCODE_WIDTH]);
	assign fetchOpcode = cpuTypesPkg::opcodeT'(
		memReadData[cpuTypesPkg::WORD_WIDTH-1 -: cpuTypesPkg::OPCODE_WIDTH]);

	assign operandAddr = instr[cpuTypesPkg::ADDR_WIDTH-1:0];
	assign operandData = instr[cpuTypesPkg::DATA_WIDTH-1:0];
	assign memValue    = operandWord[cpuTypesPkg::DATA_WIDTH-1:0];  // Low bits only

	// Operand address in execute, pc in every other phase
	assign memAddr = execute ? operandAddr : pc;

	// Fetch is the phase that precedes a normal decode
	assign haltRequest = fetch && (fetchOpcode == cpuTypesPkg::HALT);

	assign storeEnable = commit && (opcode == cpuTypesPkg::STA);
	assign storeAddr   = operandAddr;
	assign storeData   = accumulator;

	always_ff @(posedge CLK) begin
		if (execute) begin
			operandWord <= memReadData;
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			instr       <= '0;  // Decodes as NOP
			pc          <= '0;
			accumulator <= '0;
		end else begin
			if (decode) begin
				instr <= debugActive ? debugInstruction : memReadData;
			end
			if (commit) begin
				case (opcode)
					cpuTypesPkg::LDI:  accumulator <= operandData;
					cpuTypesPkg::LDA:  accumulator <= memValue;
					cpuTypesPkg::ADD:  accumulator <= accumulator + memValue;
					cpuTypesPkg::ADDI: accumulator <= accumulator + operandData;
					default:           accumulator <= accumulator;
				endcase

				// A jump also lands during a debug cycle
				if (opcode == cpuTypesPkg::JMP) begin
					pc <= operandAddr;
				end else if (pcEnable && opcode != cpuTypesPkg::HALT) begin
					pc <= pc + cpuTypesPkg::addrT'(1);
				end
			end
		end
	end

endmodule

/* verilog/debugMonitor.sv */
module debugMonitor (
	input  logic                     CLK,
	input  logic                     RESET,
	input  cpuTypesPkg::addrT        pc,
	input  logic                     breakpointEnable,
	input  debugTypesPkg::debugAddrT breakpointAddr,
	input  logic                     watchEnable,
	input  debugTypesPkg::debugAddrT watchAddr,
	input  logic                     storeEnable,
	input  cpuTypesPkg::addrT        storeAddr,
	input  logic                     debugAddrLoad,
	input  debugTypesPkg::debugAddrT debugAddrIn,
	input  logic                     readAddrInc,
	input  logic                     fetch,
	input  logic                     debugActive,
	input  debugTypesPkg::debugDataT debugMemData,
	output logic                     atBreakpoint,
	output logic                     inWatch,
	output debugTypesPkg::debugAddrT debugReadAddr,
	output debugTypesPkg::debugDataT debugReadData
);

	logic watchHit;

	assign atBreakpoint = breakpointEnable && (pc == breakpointAddr);

	// storeEnable is only high in commit
	assign watchHit = storeEnable && (storeAddr == watchAddr);

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			inWatch <= 1'b0;
		end else if (!watchEnable) begin
			inWatch <= 1'b0;  // Disabling the watch releases the stop
		end else if (watchHit) begin
			inWatch <= 1'b1;
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			debugReadAddr <= '0;
		end else if (debugAddrLoad) begin
			debugReadAddr <= debugAddrIn;  // Load wins over increment
		end else if (readAddrInc) begin
			debugReadAddr <= debugReadAddr + debugTypesPkg::debugAddrT'(1);
		end
	end

	// Captured at debug fetch, valid during the ack cycle
	always_ff @(posedge CLK) begin
		if (fetch && debugActive) begin
			debugReadData <= debugMemData;
		end
	end

endmodule

/* verilog/programMemory.sv */
module programMemory (
	input  logic                     CLK,
	input  cpuTypesPkg::addrT        coreAddr,
	input  logic                     storeEnable,
	input  cpuTypesPkg::addrT        storeAddr,
	input  cpuTypesPkg::dataT        storeData,
	input  debugTypesPkg::debugAddrT debugAddr,
	input  logic                     loadEnable,
	input  cpuTypesPkg::addrT        loadAddr,
	input  cpuTypesPkg::wordT        loadData,
	output cpuTypesPkg::wordT        coreData,
	output debugTypesPkg::debugDataT debugData
);

	cpuTypesPkg::wordT mem [cpuTypesPkg::MEM_DEPTH];

	// Core store takes the port over an external load
	always_ff @(posedge CLK) begin
		if (storeEnable) begin
			mem[storeAddr] <= cpuTypesPkg::wordT'(storeData);  // Zero-extended
		end else if (loadEnable) begin
			mem[loadAddr] <= loadData;
		end
	end

	assign coreData  = mem[coreAddr];
	assign debugData = debugTypesPkg::debugDataT'(mem[debugAddr]);

endmodule

/* verilog/debugCpu.sv */
module debugCpu (
	input  logic                     CLK,
	input  logic                     RESET,
	input  logic                     loadEnable,
	input  cpuTypesPkg::addrT        loadAddr,
	input  cpuTypesPkg::wordT        loadData,
	input  logic                     debugReq,
	input  logic                     debugModeStop,
	input  logic                     debugModeInc,
	input  cpuTypesPkg::wordT        debugInstruction,
	input  logic                     debugAddrLoad,
	input  debugTypesPkg::debugAddrT debugAddrIn,
	input  logic                     breakpointEnable,
	input  debugTypesPkg::debugAddrT breakpointAddr,
	input  logic                     watchEnable,
	input  debugTypesPkg::debugAddrT watchAddr,
	output cpuTypesPkg::addrT        pc,
	output cpuTypesPkg::dataT        accumulator,
	output logic                     halted,
	output logic                     stopped,
	output logic                     debugActive,
	output logic                     debugAck,
	output debugTypesPkg::debugDataT debugReadData
);

	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic pcEnable;
	logic readAddrInc;
	logic haltRequest;
	logic atBreakpoint;
	logic inWatch;
	logic storeEnable;
	cpuTypesPkg::addrT        memAddr;
	cpuTypesPkg::wordT        memReadData;
	cpuTypesPkg::addrT        storeAddr;
	cpuTypesPkg::dataT        storeData;
	debugTypesPkg::debugAddrT debugReadAddr;
	debugTypesPkg::debugDataT debugMemData;

	masterSequencer sequencer (
		.CLK(CLK), .RESET(RESET), .debugReq(debugReq), .debugModeStop(debugModeStop),
		.debugModeInc(debugModeInc), .atBreakpoint(atBreakpoint), .inWatch(inWatch),
		.haltRequest(haltRequest), .stopped(stopped), .fetch(fetch), .decode(decode),
		.execute(execute), .commit(commit), .debugAck(debugAck), .readAddrInc(readAddrInc),
		.halted(halted), .pcEnable(pcEnable), .debugActive(debugActive)
	);

	instructionCore core (
		.CLK(CLK), .RESET(RESET), .fetch(fetch), .decode(decode), .execute(execute),
		.commit(commit), .pcEnable(pcEnable), .debugActive(debugActive),
		.debugInstruction(debugInstruction), .memReadData(memReadData), .memAddr(memAddr),
		.pc(pc), .accumulator(accumulator), .haltRequest(haltRequest),
		.storeEnable(storeEnable), .storeAddr(storeAddr), .storeData(storeData)
	);

	debugMonitor monitor (
		.CLK(CLK), .RESET(RESET), .pc(pc), .breakpointEnable(breakpointEnable),
		.breakpointAddr(breakpointAddr), .watchEnable(watchEnable), .watchAddr(watchAddr),
		.storeEnable(storeEnable), .storeAddr(storeAddr), .debugAddrLoad(debugAddrLoad),
		.debugAddrIn(debugAddrIn), .readAddrInc(readAddrInc), .fetch(fetch),
		.debugActive(debugActive), .debugMemData(debugMemData), .atBreakpoint(atBreakpoint),
		.inWatch(inWatch), .debugReadAddr(debugReadAddr), .debugReadData(debugReadData)
	);

	programMemory memory (
		.CLK(CLK), .coreAddr(memAddr), .storeEnable(storeEnable), .storeAddr(storeAddr),
		.storeData(storeData), .debugAddr(debugReadAddr), .loadEnable(loadEnable),
		.loadAddr(loadAddr), .loadData(loadData), .coreData(memReadData),
		.debugData(debugMemData)
	);

endmodule

/* test/debugCpuTb.sv */
module debugCpuTb;

	localparam logic [1:0] KIND_SET   = 2'd0;  // Drive debug controls
	localparam logic [1:0] KIND_HALT  = 2'd1;  // Run until halted
	localparam logic [1:0] KIND_DEBUG = 2'd2;  // Run until debugActive
	localparam logic [1:0] KIND_STEP  = 2'd3;  // Inject one debug instruction
	localparam int NUM_ENTRIES  = 17;
	localparam int RESET_CYCLES = 5;

	typedef struct packed {
		logic [1:0]        kind;
		cpuTypesPkg::wordT instr;
		logic              stop;
		logic              inc;
		logic              bpEn;
		cpuTypesPkg::addrT bpAddr;
		logic              watchEn;
		cpuTypesPkg::addrT watchAddr;
		logic              setAddr;
		cpuTypesPkg::addrT addrIn;
		cpuTypesPkg::addrT expPc;
		cpuTypesPkg::dataT expAcc;
		cpuTypesPkg::wordT expRead;
	} entryT;

	logic CLK, RESET, loadEnable, debugReq, debugModeStop, debugModeInc, debugAddrLoad;
	logic breakpointEnable, watchEnable, halted, stopped, debugActive, debugAck;
	cpuTypesPkg::addrT        loadAddr, pc;
	cpuTypesPkg::wordT        loadData, debugInstruction;
	cpuTypesPkg::dataT        accumulator;
	debugTypesPkg::debugAddrT debugAddrIn, breakpointAddr, watchAddr;
	debugTypesPkg::debugDataT debugReadData;

	// LDI 05, ADDI 07, STA 30, ADDI 03, HALT
	cpuTypesPkg::wordT programImage [5] = '{12'h105, 12'h507, 12'h330, 12'h503, 12'hF00};
	cpuTypesPkg::wordT modelMem [cpuTypesPkg::MEM_DEPTH];
	cpuTypesPkg::addrT modelPc, modelReadAddr;
	cpuTypesPkg::dataT modelAcc;
	entryT scenario [$];
	entryT entry;
	entryT ctrl;  // Last control setting applied

	debugCpu uut (
		.CLK(CLK), .RESET(RESET), .loadEnable(loadEnable), .loadAddr(loadAddr),
		.loadData(loadData), .debugReq(debugReq), .debugModeStop(debugModeStop),
		.debugModeInc(debugModeInc), .debugInstruction(debugInstruction),
		.debugAddrLoad(debugAddrLoad), .debugAddrIn(debugAddrIn),
		.breakpointEnable(breakpointEnable), .breakpointAddr(breakpointAddr),
		.watchEnable(watchEnable), .watchAddr(watchAddr), .pc(pc), .accumulator(accumulator),
		.halted(halted), .stopped(stopped), .debugActive(debugActive), .debugAck(debugAck),
		.debugReadData(debugReadData)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		#((RESET_CYCLES + 40 * NUM_ENTRIES) * 100);
		$display("Timeout: the scenario table did not complete in the allowed time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	task checkValue(input string name, input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s actual=0x%0h expected=0x%0h", name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task nextSlot;  // Inputs move and outputs are sampled 10 after the edge
		@(posedge CLK);
		#10;
	endtask

	task addControl(input logic stop, input logic inc, input logic bpEn,
		input cpuTypesPkg::addrT bpAddr, input logic watchEn, input cpuTypesPkg::addrT wAddr,
		input logic setAddr, input cpuTypesPkg::addrT addrIn);
		entry = '0;
		entry.kind = KIND_SET;
		entry.stop = stop;
		entry.inc = inc;
		entry.bpEn = bpEn;
		entry.bpAddr = bpAddr;
		entry.watchEn = watchEn;
		entry.watchAddr = wAddr;
		entry.setAddr = setAddr;
		entry.addrIn = addrIn;
		scenario.push_back(entry);
	endtask

	task addAction(input logic [1:0] kind, input cpuTypesPkg::wordT instr);
		entry = '0;
		entry.kind = kind;
		entry.instr = instr;
		scenario.push_back(entry);
	endtask

	task modelExecute(input cpuTypesPkg::wordT instr, input logic debugCycle);
		cpuTypesPkg::addrT operand;
		operand = instr[7:0];
		case (instr[11:8])
			cpuTypesPkg::LDI:  modelAcc = operand;
			cpuTypesPkg::LDA:  modelAcc = modelMem[operand][7:0];
			cpuTypesPkg::STA:  modelMem[operand] = {4'h0, modelAcc};
			cpuTypesPkg::ADD:  modelAcc = modelAcc + modelMem[operand][7:0];
			cpuTypesPkg::ADDI: modelAcc = modelAcc + operand;
			default: ;
		endcase
		if (instr[11:8] == cpuTypesPkg::JMP) begin
			modelPc = operand;
		end else if (!debugCycle && instr[11:8] != cpuTypesPkg::HALT) begin
			modelPc = modelPc + 8'd1;
		end
	endtask

	// Stops before a breakpoint address, or right after a watched store
	task modelRunToStop;
		cpuTypesPkg::wordT instr;
		logic hit;
		int steps;
		hit = 1'b0;
		for (steps = 0; steps < 64 && !hit; steps++) begin
			if (ctrl.bpEn && modelPc == ctrl.bpAddr) begin
				hit = 1'b1;
			end else begin
				instr = modelMem[modelPc];
				modelExecute(instr, 1'b0);
				hit = ctrl.watchEn && instr[11:8] == cpuTypesPkg::STA &&
					instr[7:0] == ctrl.watchAddr;
			end
		end
	endtask

	task modelRunToHalt;
		int steps;
		for (steps = 0; steps < 64 && modelMem[modelPc][11:8] != cpuTypesPkg::HALT; steps++)
			modelExecute(modelMem[modelPc], 1'b0);
	endtask

	task debugStep;
		int cycles;
		while (!(debugActive === 1'b1 && stopped === 1'b1 && debugAck === 1'b0)) nextSlot();
		debugInstruction = entry.instr;
		debugReq = 1'b1;
		cycles = 0;
		do begin
			nextSlot();
			cycles++;
		end while (debugAck !== 1'b1);
		checkValue("debugAck delay", cycles, 32'd5);
		checkValue("pc", 32'(pc), 32'(entry.expPc));
		checkValue("accumulator", 32'(accumulator), 32'(entry.expAcc));
		checkValue("debugReadData", 32'(debugReadData), 32'(entry.expRead));
		repeat (6) begin
			nextSlot();
			checkValue("debugAck", 32'(debugAck), 32'd0);  // One pulse per request
		end
		debugReq = 1'b0;
		nextSlot();  // Request low re-arms the sequencer
	endtask

	initial begin
		RESET = 1'b1;
		loadEnable = 1'b1;
		loadAddr = '0;
		loadData = programImage[0];
		debugReq = 1'b0;
		debugModeStop = 1'b1;  // Hold the core until the table starts
		debugModeInc = 1'b0;
		debugInstruction = '0;
		debugAddrLoad = 1'b0;
		debugAddrIn = '0;
		breakpointEnable = 1'b0;
		breakpointAddr = '0;
		watchEnable = 1'b0;
		watchAddr = '0;
		for (int a = 0; a < cpuTypesPkg::MEM_DEPTH; a++) modelMem[a] = '0;
		for (int a = 0; a < 5; a++) modelMem[a] = programImage[a];
		modelPc = '0;
		modelAcc = '0;
		modelReadAddr = '0;
		ctrl = '0;

		addControl(1'b0, 1'b0, 1'b1, 8'h02, 1'b0, 8'h00, 1'b0, 8'h00);
		addAction(KIND_DEBUG, 12'h000);
		addAction(KIND_STEP, 12'h510);
		addAction(KIND_STEP, 12'h140);
		addControl(1'b0, 1'b1, 1'b1, 8'h02, 1'b0, 8'h00, 1'b1, 8'h01);
		addAction(KIND_STEP, 12'h000);
		addAction(KIND_STEP, 12'h000);
		addControl(1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 8'h30, 1'b0, 8'h00);
		addAction(KIND_DEBUG, 12'h000);
		addControl(1'b1, 1'b0, 1'b0, 8'h00, 1'b1, 8'h30, 1'b1, 8'h30);
		addAction(KIND_STEP, 12'h000);
		addAction(KIND_STEP, 12'h502);
		addAction(KIND_STEP, 12'h430);
		addControl(1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 8'h00, 1'b0, 8'h00);
		addAction(KIND_HALT, 12'h000);
		addControl(1'b1, 1'b0, 1'b0, 8'h00, 1'b0, 8'h00, 1'b1, 8'h30);
		addAction(KIND_STEP, 12'h230);

		nextSlot();
		checkValue("stopped", 32'(stopped), 32'd1);
		checkValue("debugActive", 32'(debugActive), 32'd0);
		checkValue("debugAck", 32'(debugAck), 32'd0);
		for (int a = 1; a < 5; a++) begin
			loadAddr = 8'(a);
			loadData = programImage[a];
			nextSlot();
		end
		RESET = 1'b0;
		loadEnable = 1'b0;

		for (int i = 0; i < scenario.size(); i++) begin
			entry = scenario[i];
			case (entry.kind)
				KIND_SET: begin
					debugModeStop = entry.stop;
					debugModeInc = entry.inc;
					breakpointEnable = entry.bpEn;
					breakpointAddr = entry.bpAddr;
					watchEnable = entry.watchEn;
					watchAddr = entry.watchAddr;
					debugAddrIn = entry.addrIn;
					debugAddrLoad = entry.setAddr;
					if (entry.setAddr) modelReadAddr = entry.addrIn;
					ctrl = entry;
					nextSlot();
					debugAddrLoad = 1'b0;
				end
				KIND_STEP: begin
					modelExecute(entry.instr, 1'b1);
					entry.expRead = modelMem[modelReadAddr];
					if (ctrl.inc) modelReadAddr = modelReadAddr + 8'd1;
					entry.expPc = modelPc;
					entry.expAcc = modelAcc;
					debugStep();
				end
				default: begin
					if (entry.kind == KIND_HALT) begin
						modelRunToHalt();
						while (halted !== 1'b1) nextSlot();
					end else begin
						modelRunToStop();
						while (debugActive !== 1'b0) nextSlot();
						while (debugActive !== 1'b1) nextSlot();
					end
					entry.expPc = modelPc;
					entry.expAcc = modelAcc;
					checkValue("pc", 32'(pc), 32'(entry.expPc));
					checkValue("accumulator", 32'(accumulator), 32'(entry.expAcc));
				end
			endcase
			scenario[i] = entry;
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* debugCpu.f */
verilog/cpuTypesPkg.sv
verilog/debugTypesPkg.sv
verilog/masterSequencer.sv
verilog/instructionCore.sv
verilog/debugMonitor.sv
verilog/programMemory.sv
verilog/debugCpu.sv
test/debugCpuTb.sv

/* runSim.sh */
#!/bin/bash
# Compile and run the debugCpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module debugCpuTb -Mdir obj_dir -f debugCpu.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/VdebugCpuTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
